// File: hw/apb_decode.sv
// APB setup/access decoder; expects a setup cycle before every access, no wait states inserted
`default_nettype none

module apb_decode import regfile_pkg::*; #(
    parameter paddr_t BASE_ADDR = '0
) (
    input  logic     pclk,
    input  logic     rst,
    input  apb_req_t req,
    output reg_acc_t acc
);

    // -------------------------------------------------------------------------
    // Setup phase address check
    // -------------------------------------------------------------------------
    paddr_t   offset;
    reg_idx_t idx_d;
    logic     in_range;
    logic     err_d;
    logic     setup;

    // Word offset into the block
    assign offset   = req.addr - BASE_ADDR;
    assign in_range = offset < paddr_t'(NUM_REGS);
    assign idx_d    = offset[IDX_W-1:0];

    // Unmapped, or a write to the read-only capture
    assign err_d = !in_range || (req.write && (idx_d == REG_MDIO_DATA));

    // Select without enable
    assign setup = req.sel && !req.enable;

    // -------------------------------------------------------------------------
    // Held decode for the access cycle
    // -------------------------------------------------------------------------
    reg_idx_t idx_q;
    logic     err_q;

    // A held setup simply recaptures the same result
    always_ff @(posedge pclk) begin
        if (rst) begin
            idx_q <= '0;
            err_q <= 1'b0;
        end else if (setup) begin
            idx_q <= idx_d;
            err_q <= err_d;
        end
    end

    // -------------------------------------------------------------------------
    // Access record
    // -------------------------------------------------------------------------
    logic access;

    // Select and enable together
    assign access = req.sel && req.enable;

    assign acc.idx   = idx_q;
    assign acc.acc   = access;
    assign acc.err   = err_q;
    assign acc.wdata = req.wdata;

    // Legal writes only reach the storage
    assign acc.wr_en = access && req.write && !err_q;

    // Reads flagged whether legal or not; result gates on err
    assign acc.rd    = access && !req.write;

endmodule

`default_nettype wire

// File: hw/regfile_pkg.sv
// Shared types for the APB register file; word addressed, 16-bit data, no wait states or pstrb
`default_nettype none

package regfile_pkg;

    // -------------------------------------------------------------------------
    // Bus and field widths
    // -------------------------------------------------------------------------
    localparam int ADDR_W = 21;
    localparam int DATA_W = 16;
    localparam int IDX_W  = 4;
    localparam int MDIO_W = 9;

    typedef logic [ADDR_W-1:0] paddr_t;
    typedef logic [DATA_W-1:0] pdata_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;
    typedef logic [MDIO_W-1:0] mdio_data_t;
    // PHY address, mask and broadcast address share one width
    typedef logic [4:0]        phy_addr_t;
    // Packet clock divider and phase
    typedef logic [8:0]        clk_ctl_t;

    // -------------------------------------------------------------------------
    // Register map
    // -------------------------------------------------------------------------
    localparam reg_idx_t REG_PHY_CFG   = 4'd0;
    localparam reg_idx_t REG_PHY_CTRL  = 4'd1;
    localparam reg_idx_t REG_CLK_DIV   = 4'd2;
    localparam reg_idx_t REG_CLK_PHASE = 4'd3;
    localparam reg_idx_t REG_CTRL      = 4'd4;
    localparam reg_idx_t REG_CMD       = 4'd5;
    localparam reg_idx_t REG_IDLE_LEN  = 4'd6;
    localparam reg_idx_t REG_MDIO_SEL  = 4'd7;
    localparam reg_idx_t REG_MDIO_ADDR = 4'd8;
    localparam reg_idx_t REG_MDIO_DATA = 4'd9;
    localparam int       NUM_REGS      = 10;

    // Reset words, laid out as the registers read back
    localparam pdata_t RST_PHY_CFG   = 16'h0000;
    localparam pdata_t RST_PHY_CTRL  = 16'h0000;
    localparam pdata_t RST_CLK_DIV   = 16'h0000;
    localparam pdata_t RST_CLK_PHASE = 16'h0000;
    // Both software resets released
    localparam pdata_t RST_CTRL      = 16'h0006;
    localparam pdata_t RST_CMD       = 16'h0000;
    localparam pdata_t RST_IDLE_LEN  = 16'h0040;
    localparam pdata_t RST_MDIO_SEL  = 16'h0000;
    localparam pdata_t RST_MDIO_ADDR = 16'h0000;
    // Capture empty, valid flag clear
    localparam pdata_t RST_MDIO_DATA = 16'h0000;

    // -------------------------------------------------------------------------
    // Bundles
    // -------------------------------------------------------------------------
    typedef struct packed {
        paddr_t addr;
        logic   write;
        logic   sel;
        logic   enable;
        pdata_t wdata;
    } apb_req_t;

    // Decoded access, valid in the access phase
    typedef struct packed {
        reg_idx_t idx;
        logic     acc;
        logic     wr_en;
        logic     rd;
        logic     err;
        pdata_t   wdata;
    } reg_acc_t;

    typedef struct packed {
        phy_addr_t   legal_phy_addr;
        phy_addr_t   legal_phy_addr_mask;
        phy_addr_t   broadcast_addr;
        logic        broadcast_mode;
        logic        non_zero_detect;
        logic        opendrain_mode;
        logic        watchdog_enable;
        logic        sync_select;
        clk_ctl_t    clk_div;
        clk_ctl_t    clk_phase;
        logic        clk_en;
        logic        pktctrl_sw_rstn;
        logic        regfile_sw_rstn;
        logic        self_test_mode;
        logic        capture_mode;
        logic        path96_en;
        logic [1:0]  pkt_data_length;
        pdata_t      idle_length;
        logic [6:0]  mdio_data_sel;
        logic [14:0] mdio_memory_addr;
    } cfg_t;

    // Last field is bit 0, matching CMD bit order
    typedef struct packed {
        logic mdio_read_pulse;
        logic capture_again;
        logic capture_start;
    } cmd_t;

endpackage

`default_nettype wire

// File: hw/regfile_readback.sv
// Read data and response for the access phase; pready is combinational, no wait states
`default_nettype none

module regfile_readback import regfile_pkg::*; (
    input  reg_acc_t   acc,
    input  cfg_t       cfg,
    input  mdio_data_t mdio_data,
    input  logic       mdio_valid,
    output pdata_t     prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       mdio_rd_clr
);

    // -------------------------------------------------------------------------
    // Register word reassembly
    // -------------------------------------------------------------------------
    pdata_t word;

    // Unused bits stay zero
    always_comb begin
        word = '0;
        case (acc.idx)
            REG_PHY_CFG: begin
                word = {cfg.broadcast_mode, cfg.broadcast_addr,
                        cfg.legal_phy_addr_mask, cfg.legal_phy_addr};
            end
            REG_PHY_CTRL: begin
                word[3:0] = {cfg.sync_select, cfg.watchdog_enable,
                             cfg.opendrain_mode, cfg.non_zero_detect};
            end
            REG_CLK_DIV:   word[8:0] = cfg.clk_div;
            REG_CLK_PHASE: word[8:0] = cfg.clk_phase;
            REG_CTRL: begin
                word[7:0] = {cfg.pkt_data_length, cfg.path96_en, cfg.capture_mode,
                             cfg.self_test_mode, cfg.regfile_sw_rstn,
                             cfg.pktctrl_sw_rstn, cfg.clk_en};
            end
            // Pulses are not readable
            REG_CMD:       word = '0;
            REG_IDLE_LEN:  word = cfg.idle_length;
            REG_MDIO_SEL:  word[6:0] = cfg.mdio_data_sel;
            REG_MDIO_ADDR: word[14:0] = cfg.mdio_memory_addr;
            REG_MDIO_DATA: begin
                word[MDIO_W-1:0] = mdio_data;
                word[DATA_W-1]   = mdio_valid;
            end
            default:       word = '0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Response
    // -------------------------------------------------------------------------
    // Zero outside the access cycle and on error
    assign prdata  = (acc.acc && !acc.err) ? word : '0;
    assign pready  = acc.acc;
    assign pslverr = acc.acc && acc.err;

    // Legal read of the capture drops its valid flag
    assign mdio_rd_clr = acc.rd && !acc.err && (acc.idx == REG_MDIO_DATA);

endmodule

`default_nettype wire

// File: hw/regfile_regs.sv
// Register storage and command pulses; software reset restores every register one cycle later
`default_nettype none

module regfile_regs import regfile_pkg::*; (
    input  logic       pclk,
    input  logic       rst,
    input  reg_acc_t   acc,
    input  mdio_data_t mdio_pkt_data,
    input  logic       mdio_pkt_data_we,
    input  logic       mdio_rd_clr,
    output cfg_t       cfg,
    output cmd_t       cmd,
    output mdio_data_t mdio_data,
    output logic       mdio_valid
);

    // -------------------------------------------------------------------------
    // Register word to field mapping
    // -------------------------------------------------------------------------

    // Apply one register word to the configuration
    function automatic cfg_t cfg_write(cfg_t cur, reg_idx_t idx, pdata_t d);
        cfg_t nxt;
        nxt = cur;
        case (idx)
            REG_PHY_CFG: begin
                nxt.legal_phy_addr      = d[4:0];
                nxt.legal_phy_addr_mask = d[9:5];
                nxt.broadcast_addr      = d[14:10];
                nxt.broadcast_mode      = d[15];
            end
            REG_PHY_CTRL: begin
                nxt.non_zero_detect = d[0];
                nxt.opendrain_mode  = d[1];
                nxt.watchdog_enable = d[2];
                nxt.sync_select     = d[3];
            end
            REG_CLK_DIV: begin
                nxt.clk_div = d[8:0];
            end
            REG_CLK_PHASE: begin
                nxt.clk_phase = d[8:0];
            end
            REG_CTRL: begin
                nxt.clk_en          = d[0];
                nxt.pktctrl_sw_rstn = d[1];
                nxt.regfile_sw_rstn = d[2];
                nxt.self_test_mode  = d[3];
                nxt.capture_mode    = d[4];
                nxt.path96_en       = d[5];
                nxt.pkt_data_length = d[7:6];
            end
            REG_IDLE_LEN: begin
                nxt.idle_length = d;
            end
            REG_MDIO_SEL: begin
                nxt.mdio_data_sel = d[6:0];
            end
            REG_MDIO_ADDR: begin
                nxt.mdio_memory_addr = d[14:0];
            end
            // CMD and MDIO_DATA hold no configuration
            default: begin
                nxt = cur;
            end
        endcase
        return nxt;
    endfunction

    // Reset image built from the per-register reset words
    function automatic cfg_t cfg_defaults();
        cfg_t c;
        c = '0;
        c = cfg_write(c, REG_PHY_CFG, RST_PHY_CFG);
        c = cfg_write(c, REG_PHY_CTRL, RST_PHY_CTRL);
        c = cfg_write(c, REG_CLK_DIV, RST_CLK_DIV);
        c = cfg_write(c, REG_CLK_PHASE, RST_CLK_PHASE);
        c = cfg_write(c, REG_CTRL, RST_CTRL);
        c = cfg_write(c, REG_IDLE_LEN, RST_IDLE_LEN);
        c = cfg_write(c, REG_MDIO_SEL, RST_MDIO_SEL);
        c = cfg_write(c, REG_MDIO_ADDR, RST_MDIO_ADDR);
        return c;
    endfunction

    // -------------------------------------------------------------------------
    // Configuration storage
    // -------------------------------------------------------------------------
    cfg_t cfg_q;
    logic soft_rst;

    // Stored bit low for one cycle, then everything reloads
    assign soft_rst = !cfg_q.regfile_sw_rstn;

    always_ff @(posedge pclk) begin
        if (rst || soft_rst) begin
            cfg_q <= cfg_defaults();
        end else if (acc.wr_en) begin
            cfg_q <= cfg_write(cfg_q, acc.idx, acc.wdata);
        end
    end

    assign cfg = cfg_q;

    // -------------------------------------------------------------------------
    // Command pulses
    // -------------------------------------------------------------------------
    cmd_t cmd_q;

    // Write-one bits, high for the single cycle after the access edge
    always_ff @(posedge pclk) begin
        if (rst || soft_rst) begin
            cmd_q <= cmd_t'(RST_CMD[$bits(cmd_t)-1:0]);
        end else if (acc.wr_en && (acc.idx == REG_CMD)) begin
            cmd_q <= cmd_t'(acc.wdata[$bits(cmd_t)-1:0]);
        end else begin
            cmd_q <= '0;
        end
    end

    assign cmd = cmd_q;

    // -------------------------------------------------------------------------
    // MDIO packet data capture
    // -------------------------------------------------------------------------
    mdio_data_t mdio_data_q;
    logic       mdio_valid_q;

    // Strobe beats a same-cycle read-clear
    always_ff @(posedge pclk) begin
        if (rst || soft_rst) begin
            mdio_data_q  <= RST_MDIO_DATA[MDIO_W-1:0];
            mdio_valid_q <= RST_MDIO_DATA[DATA_W-1];
        end else if (mdio_pkt_data_we) begin
            mdio_data_q  <= mdio_pkt_data;
            mdio_valid_q <= 1'b1;
        end else if (mdio_rd_clr) begin
            mdio_valid_q <= 1'b0;
        end
    end

    assign mdio_data  = mdio_data_q;
    assign mdio_valid = mdio_valid_q;

endmodule

`default_nettype wire

// File: hw/top_regfile.sv
// APB register file top; BASE_ADDR is a word address, block spans ten words from it
`default_nettype none

module top_regfile import regfile_pkg::*; #(
    parameter paddr_t BASE_ADDR = '0
) (
    input  logic        pclk,
    input  logic        rst,

    // APB slave
    input  logic [20:0] req_paddr,
    input  logic        req_pwrite,
    input  logic        req_psel,
    input  logic        req_penable,
    input  logic [15:0] req_pwdata,
    output logic        req_pready,
    output logic [15:0] req_prdata,
    output logic        req_pslverr,

    // PHY management configuration
    output logic [4:0]  legal_phy_addr,
    output logic [4:0]  legal_phy_addr_mask,
    output logic [4:0]  broadcast_addr,
    output logic        broadcast_mode,
    output logic        non_zero_detect,
    output logic        opendrain_mode,
    output logic        watchdog_enable,
    output logic        sync_select,

    // Packet control configuration
    output logic [8:0]  rf_pktctrl_clk_div,
    output logic [8:0]  rf_pktctrl_clk_phase,
    output logic        rf_pktctrl_clk_en,
    output logic        rf_pktctrl_sw_rstn,
    output logic        rf_regfile_sw_rstn,
    output logic        rf_self_test_mode,
    output logic        rf_capture_mode,
    output logic        rf_capture_start,
    output logic        rf_capture_again,
    output logic        rf_96path_en,
    output logic [1:0]  rf_pkt_data_length,
    output logic [15:0] rf_pkt_idle_length,

    // MDIO side
    output logic        rf_mdio_read_pulse,
    output logic [6:0]  rf_mdio_data_sel,
    output logic [14:0] rf_mdio_memory_addr,
    input  logic [8:0]  rf_mdio_pkt_data,
    input  logic        rf_mdio_pkt_data_we
);

    apb_req_t   req;
    reg_acc_t   acc;
    cfg_t       cfg;
    cmd_t       cmd;
    mdio_data_t mdio_data;
    logic       mdio_valid;
    logic       mdio_rd_clr;

    // Bus into one record
    assign req.addr   = req_paddr;
    assign req.write  = req_pwrite;
    assign req.sel    = req_psel;
    assign req.enable = req_penable;
    assign req.wdata  = req_pwdata;

    apb_decode #(
        .BASE_ADDR (BASE_ADDR)
    ) decode_i (
        .pclk (pclk),
        .rst  (rst),
        .req  (req),
        .acc  (acc)
    );

    regfile_regs regs_i (
        .pclk             (pclk),
        .rst              (rst),
        .acc              (acc),
        .mdio_pkt_data    (rf_mdio_pkt_data),
        .mdio_pkt_data_we (rf_mdio_pkt_data_we),
        .mdio_rd_clr      (mdio_rd_clr),
        .cfg              (cfg),
        .cmd              (cmd),
        .mdio_data        (mdio_data),
        .mdio_valid       (mdio_valid)
    );

    regfile_readback readback_i (
        .acc         (acc),
        .cfg         (cfg),
        .mdio_data   (mdio_data),
        .mdio_valid  (mdio_valid),
        .prdata      (req_prdata),
        .pready      (req_pready),
        .pslverr     (req_pslverr),
        .mdio_rd_clr (mdio_rd_clr)
    );

    // -------------------------------------------------------------------------
    // Configuration fan-out
    // -------------------------------------------------------------------------
    assign legal_phy_addr       = cfg.legal_phy_addr;
    assign legal_phy_addr_mask  = cfg.legal_phy_addr_mask;
    assign broadcast_addr       = cfg.broadcast_addr;
    assign broadcast_mode       = cfg.broadcast_mode;
    assign non_zero_detect      = cfg.non_zero_detect;
    assign opendrain_mode       = cfg.opendrain_mode;
    assign watchdog_enable      = cfg.watchdog_enable;
    assign sync_select          = cfg.sync_select;
    assign rf_pktctrl_clk_div   = cfg.clk_div;
    assign rf_pktctrl_clk_phase = cfg.clk_phase;
    assign rf_pktctrl_clk_en    = cfg.clk_en;
    assign rf_pktctrl_sw_rstn   = cfg.pktctrl_sw_rstn;
    assign rf_regfile_sw_rstn   = cfg.regfile_sw_rstn;
    assign rf_self_test_mode    = cfg.self_test_mode;
    assign rf_capture_mode      = cfg.capture_mode;
    assign rf_96path_en         = cfg.path96_en;
    assign rf_pkt_data_length   = cfg.pkt_data_length;
    assign rf_pkt_idle_length   = cfg.idle_length;
    assign rf_mdio_data_sel     = cfg.mdio_data_sel;
    assign rf_mdio_memory_addr  = cfg.mdio_memory_addr;

    // One-cycle command pulses
    assign rf_capture_start     = cmd.capture_start;
    assign rf_capture_again     = cmd.capture_again;
    assign rf_mdio_read_pulse   = cmd.mdio_read_pulse;

endmodule

`default_nettype wire

// File: regfile.f
hw/regfile_pkg.sv
hw/apb_decode.sv
hw/regfile_regs.sv
hw/regfile_readback.sv
hw/top_regfile.sv
verif/tb_top_regfile.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the APB register file testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f regfile.f --top-module tb_top_regfile

# A failing run stops through $fatal, so the log decides the outcome
./obj_dir/Vtb_top_regfile > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "FAIL: run ended without a result line"
    exit 1
fi
echo "PASS"

// File: verif/regfile_cases.txt
# op sel data expect err; op is W write, R read, M mdio strobe, P pulse check, O output check
# sel is a word offset from BASE or an O field code; hex values, r is random, - is unused
R 0 - 0000 0
R 1 - 0000 0
R 2 - 0000 0
R 3 - 0000 0
R 4 - 0006 0
R 5 - 0000 0
R 6 - 0040 0
R 7 - 0000 0
R 8 - 0000 0
R 9 - 0000 0
O b - 1 0
O c - 1 0
P - - 0 0
O 14 - 0 0
# write and read back
W 0 a5c3 - 0
O 0 - 03 0
O 1 - 0e 0
O 2 - 09 0
O 3 - 1 0
R 0 - a5c3 0
W 1 fffa - 0
O 5 - 1 0
R 1 - 000a 0
W 2 r - 0
R 2 - r 0
W 3 fe37 - 0
O 9 - 037 0
R 3 - 0037 0
W 4 ffff - 0
O 10 - 3 0
R 4 - 00ff 0
W 6 r - 0
R 6 - r 0
W 7 r - 0
R 7 - r 0
W 8 ffff - 0
O 13 - 7fff 0
R 8 - 7fff 0
# unmapped addresses and the read-only capture
W a 1234 - 1
R a - 0000 1
W 1fffff 0000 - 1
W 9 ffff - 1
O 0 - 03 0
R 0 - a5c3 0
R 9 - 0000 0
# command pulses
W 5 0005 - 0
P - - 5 0
P - - 0 0
W 5 0002 - 0
P - - 2 0
P - - 0 0
R 5 - 0000 0
# mdio capture
M - 1a7 - 0
R 9 - 81a7 0
R 9 - 01a7 0
# software reset
W 4 00fb - 0
O c - 0 0
O c - 1 0
R 0 - 0000 0
R 1 - 0000 0
R 2 - 0000 0
R 3 - 0000 0
R 4 - 0006 0
R 5 - 0000 0
R 6 - 0040 0
R 7 - 0000 0
R 8 - 0000 0
R 9 - 0000 0

// File: verif/tb_top_regfile.sv
// Run from the project root; case addresses are word offsets from BASE, idle cycles between transfers
`default_nettype none

module tb_top_regfile;

    // -------------------------------------------------------------------------
    // DUT signals
    // -------------------------------------------------------------------------
    localparam logic [20:0] BASE = 21'h000120;

    logic        pclk = 1'b0;
    logic        rst;
    logic [20:0] req_paddr;
    logic        req_pwrite;
    logic        req_psel;
    logic        req_penable;
    logic [15:0] req_pwdata;
    logic        req_pready;
    logic [15:0] req_prdata;
    logic        req_pslverr;
    logic [4:0]  legal_phy_addr;
    logic [4:0]  legal_phy_addr_mask;
    logic [4:0]  broadcast_addr;
    logic        broadcast_mode;
    logic        non_zero_detect;
    logic        opendrain_mode;
    logic        watchdog_enable;
    logic        sync_select;
    logic [8:0]  rf_pktctrl_clk_div;
    logic [8:0]  rf_pktctrl_clk_phase;
    logic        rf_pktctrl_clk_en;
    logic        rf_pktctrl_sw_rstn;
    logic        rf_regfile_sw_rstn;
    logic        rf_self_test_mode;
    logic        rf_capture_mode;
    logic        rf_capture_start;
    logic        rf_capture_again;
    logic        rf_96path_en;
    logic [1:0]  rf_pkt_data_length;
    logic [15:0] rf_pkt_idle_length;
    logic        rf_mdio_read_pulse;
    logic [6:0]  rf_mdio_data_sel;
    logic [14:0] rf_mdio_memory_addr;
    logic [8:0]  rf_mdio_pkt_data;
    logic        rf_mdio_pkt_data_we;

    // Masked value of the last random write
    logic [15:0] last_rand;

    // Write check already moved time to the falling edge
    logic        at_negedge;

    top_regfile #(
        .BASE_ADDR (BASE)
    ) dut_i (
        .pclk (pclk), .rst (rst),
        .req_paddr (req_paddr), .req_pwrite (req_pwrite), .req_psel (req_psel),
        .req_penable (req_penable), .req_pwdata (req_pwdata), .req_pready (req_pready),
        .req_prdata (req_prdata), .req_pslverr (req_pslverr),
        .legal_phy_addr (legal_phy_addr), .legal_phy_addr_mask (legal_phy_addr_mask),
        .broadcast_addr (broadcast_addr), .broadcast_mode (broadcast_mode),
        .non_zero_detect (non_zero_detect), .opendrain_mode (opendrain_mode),
        .watchdog_enable (watchdog_enable), .sync_select (sync_select),
        .rf_pktctrl_clk_div (rf_pktctrl_clk_div), .rf_pktctrl_clk_phase (rf_pktctrl_clk_phase),
        .rf_pktctrl_clk_en (rf_pktctrl_clk_en), .rf_pktctrl_sw_rstn (rf_pktctrl_sw_rstn),
        .rf_regfile_sw_rstn (rf_regfile_sw_rstn), .rf_self_test_mode (rf_self_test_mode),
        .rf_capture_mode (rf_capture_mode), .rf_capture_start (rf_capture_start),
        .rf_capture_again (rf_capture_again), .rf_96path_en (rf_96path_en),
        .rf_pkt_data_length (rf_pkt_data_length), .rf_pkt_idle_length (rf_pkt_idle_length),
        .rf_mdio_read_pulse (rf_mdio_read_pulse), .rf_mdio_data_sel (rf_mdio_data_sel),
        .rf_mdio_memory_addr (rf_mdio_memory_addr), .rf_mdio_pkt_data (rf_mdio_pkt_data),
        .rf_mdio_pkt_data_we (rf_mdio_pkt_data_we)
    );

    // Period 100
    always #50 pclk = ~pclk;

    // -------------------------------------------------------------------------
    // Reference rules and reporting
    // -------------------------------------------------------------------------

    // Readable bits per register word
    function automatic logic [15:0] reg_mask(input int offs);
        case (offs)
            0, 6:    return 16'hffff;
            1:       return 16'h000f;
            2, 3:    return 16'h01ff;
            4:       return 16'h00ff;
            7:       return 16'h007f;
            8:       return 16'h7fff;
            default: return 16'h0000;
        endcase
    endfunction

    // Register word rebuilt from the output ports, by the register map
    function automatic logic [15:0] port_word(input int offs);
        case (offs)
            0:       return {broadcast_mode, broadcast_addr, legal_phy_addr_mask,
                             legal_phy_addr};
            1:       return {12'd0, sync_select, watchdog_enable, opendrain_mode,
                             non_zero_detect};
            2:       return {7'd0, rf_pktctrl_clk_div};
            3:       return {7'd0, rf_pktctrl_clk_phase};
            4:       return {8'd0, rf_pkt_data_length, rf_96path_en, rf_capture_mode,
                             rf_self_test_mode, rf_regfile_sw_rstn, rf_pktctrl_sw_rstn,
                             rf_pktctrl_clk_en};
            6:       return rf_pkt_idle_length;
            7:       return {9'd0, rf_mdio_data_sel};
            8:       return {1'b0, rf_mdio_memory_addr};
            default: return 16'h0000;
        endcase
    endfunction

    // Output port picked by an O line, zero extended
    function automatic logic [15:0] probe_output(input int sel);
        logic [15:0] v;
        v = 16'h0000;
        case (sel)
            0:  v[4:0]  = legal_phy_addr;
            1:  v[4:0]  = legal_phy_addr_mask;
            2:  v[4:0]  = broadcast_addr;
            3:  v[0]    = broadcast_mode;
            4:  v[0]    = non_zero_detect;
            5:  v[0]    = opendrain_mode;
            6:  v[0]    = watchdog_enable;
            7:  v[0]    = sync_select;
            8:  v[8:0]  = rf_pktctrl_clk_div;
            9:  v[8:0]  = rf_pktctrl_clk_phase;
            10: v[0]    = rf_pktctrl_clk_en;
            11: v[0]    = rf_pktctrl_sw_rstn;
            12: v[0]    = rf_regfile_sw_rstn;
            13: v[0]    = rf_self_test_mode;
            14: v[0]    = rf_capture_mode;
            15: v[0]    = rf_96path_en;
            16: v[1:0]  = rf_pkt_data_length;
            17: v       = rf_pkt_idle_length;
            18: v[6:0]  = rf_mdio_data_sel;
            19: v[14:0] = rf_mdio_memory_addr;
            default: v[0] = req_pready;
        endcase
        return v;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // -------------------------------------------------------------------------
    // Bus and case execution
    // -------------------------------------------------------------------------

    // Setup cycle, then access cycle; returns on the edge that ends the access
    task automatic apb_transfer(input logic wr, input logic [20:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic slverr);
        int waits;
        waits = 0;
        @(posedge pclk);
        req_psel    <= 1'b1;
        req_penable <= 1'b0;
        req_pwrite  <= wr;
        req_paddr   <= addr;
        req_pwdata  <= wdata;
        @(negedge pclk);
        check_value("pready in setup cycle", {15'd0, req_pready}, 16'h0000);
        @(posedge pclk);
        req_penable <= 1'b1;
        @(negedge pclk);
        while (!req_pready && waits < 8) begin
            waits = waits + 1;
            @(negedge pclk);
        end
        assert (req_pready) else begin
            $display("Timeout: pready stayed low for 8 cycles of the access phase");
            abort_run();
        end
        rdata  = req_prdata;
        slverr = req_pslverr;
        @(posedge pclk);
        req_psel    <= 1'b0;
        req_penable <= 1'b0;
    endtask

    task automatic run_case(input string op, input string a_s, input string d_s,
                            input string e_s, input string r_s);
        int          a_val;
        int          d_val;
        int          e_val;
        int          r_val;
        int          i;
        logic [31:0] rnd;
        logic [20:0] addr;
        logic [15:0] data;
        logic [15:0] expv;
        logic [15:0] fexp;
        logic [15:0] rdata;
        logic        slverr;
        logic        synced;
        logic [15:0] prior [0:8];
        synced     = at_negedge;
        at_negedge = 1'b0;
        a_val = a_s.atohex();
        d_val = d_s.atohex();
        e_val = e_s.atohex();
        r_val = r_s.atohex();
        // Offset wraps inside the 21-bit address space
        addr  = BASE + a_val[20:0];
        data  = d_val[15:0];
        expv  = e_val[15:0];
        if (d_s == "r") begin
            rnd       = $urandom;
            data      = rnd[15:0];
            last_rand = data & reg_mask(a_val);
        end
        if (e_s == "r") begin
            expv = last_rand;
        end
        if (op == "W") begin
            // Port image before the write, sampled on a falling edge
            if (!synced) begin
                @(negedge pclk);
            end
            for (i = 0; i < 9; i++) begin
                prior[i] = port_word(i);
            end
            apb_transfer(1'b1, addr, data, rdata, slverr);
            check_value($sformatf("pslverr of write to %h", addr), {15'd0, slverr},
                        {15'd0, r_val[0]});
            // Written fields show on the cycle after the access edge, the rest hold
            @(negedge pclk);
            at_negedge = 1'b1;
            for (i = 0; i < 9; i++) begin
                fexp = prior[i];
                if (i == a_val && !r_val[0]) begin
                    fexp = data & reg_mask(i);
                end
                check_value($sformatf("output fields of register %0d", i), port_word(i),
                            fexp);
            end
        end else if (op == "R") begin
            apb_transfer(1'b0, addr, 16'h0000, rdata, slverr);
            check_value($sformatf("pslverr of read from %h", addr), {15'd0, slverr},
                        {15'd0, r_val[0]});
            check_value($sformatf("prdata from %h", addr), rdata, expv);
        end else if (op == "M") begin
            // One-cycle strobe from the MDIO side
            @(posedge pclk);
            rf_mdio_pkt_data    <= data[8:0];
            rf_mdio_pkt_data_we <= 1'b1;
            @(posedge pclk);
            rf_mdio_pkt_data_we <= 1'b0;
        end else if (op == "P") begin
            if (!synced) begin
                @(negedge pclk);
            end
            check_value("command pulses", {13'd0, rf_mdio_read_pulse, rf_capture_again,
                        rf_capture_start}, expv);
        end else if (op == "O") begin
            if (!synced) begin
                @(negedge pclk);
            end
            check_value($sformatf("output field %0d", a_val), probe_output(a_val), expv);
        end else begin
            $display("Case file holds an unknown opcode %s", op);
            abort_run();
        end
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        int    fd;
        int    code;
        string op;
        string a_s;
        string d_s;
        string e_s;
        string r_s;
        string rest;
        rst                 <= 1'b1;
        req_paddr           <= '0;
        req_pwrite          <= 1'b0;
        req_psel            <= 1'b0;
        req_penable         <= 1'b0;
        req_pwdata          <= '0;
        rf_mdio_pkt_data    <= '0;
        rf_mdio_pkt_data_we <= 1'b0;
        last_rand           = 16'h0000;
        at_negedge          = 1'b0;
        void'($urandom(32'h9b73));
        repeat (5) @(posedge pclk);
        rst <= 1'b0;

        fd = $fopen("verif/regfile_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open verif/regfile_cases.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            // Comment lines start with a hash
            if (op.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%s %s %s %s", a_s, d_s, e_s, r_s);
                assert (code == 4) else begin
                    $display("Case line starting with %s has missing fields", op);
                    abort_run();
                end
                run_case(op, a_s, d_s, e_s, r_s);
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
